// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_top
FILELIST  := sources.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BINARY  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== design/axil_decoder.sv ====
`timescale 1ns/1ps

module axil_decoder #(
    parameter soc_pkg::addr_t CLINT_BASE = 32'h0200_0000,
    parameter soc_pkg::addr_t RAM_BASE   = 32'h8000_0000,
    parameter int             RAM_WORDS  = 64
) (
    input  logic               clk,
    input  logic               reset,
    input  soc_pkg::axil_m2s_t m_in,
    output soc_pkg::axil_s2m_t m_out,
    output soc_pkg::axil_m2s_t clint_req,
    input  soc_pkg::axil_s2m_t clint_rsp,
    output soc_pkg::axil_m2s_t ram_req,
    input  soc_pkg::axil_s2m_t ram_rsp
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        TGT_CLINT,
        TGT_RAM,
        TGT_ERR
    } target_t;

    target_t   target;
    target_t   decoded;
    logic      busy;
    addr_t     req_addr;
    axil_m2s_t err_req;
    axil_s2m_t err_rsp;
    logic      e_wack;
    logic      e_rack;
    logic      e_bvalid;
    logic      e_rvalid;

    function automatic axil_m2s_t gate(input axil_m2s_t m, input logic en);
        axil_m2s_t g;
        g         = m;
        g.awvalid = m.awvalid & en;
        g.wvalid  = m.wvalid & en;
        g.arvalid = m.arvalid & en;
        return g;
    endfunction

    // only one of the two address channels is active at a time
    assign req_addr = m_in.arvalid ? m_in.araddr : m_in.awaddr;

    always_comb begin
        if (addr_t'(req_addr - CLINT_BASE) < addr_t'(16))
            decoded = TGT_CLINT;
        else if (addr_t'(req_addr - RAM_BASE) < addr_t'(RAM_WORDS * 4))
            decoded = TGT_RAM;
        else
            decoded = TGT_ERR;
    end

    assign clint_req = gate(m_in, busy && target == TGT_CLINT);
    assign ram_req   = gate(m_in, busy && target == TGT_RAM);
    assign err_req   = gate(m_in, busy && target == TGT_ERR);

    always_comb begin
        m_out = '0;
        if (busy) begin
            case (target)
                TGT_CLINT: m_out = clint_rsp;
                TGT_RAM:   m_out = ram_rsp;
                default:   m_out = err_rsp;
            endcase
        end
    end

    // target held from address until the response handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            target <= TGT_ERR;
        end else if (!busy) begin
            if (m_in.arvalid || m_in.awvalid) begin
                busy   <= 1'b1;
                target <= decoded;
            end
        end else if ((m_out.bvalid && m_in.bready) || (m_out.rvalid && m_in.rready)) begin
            busy <= 1'b0;
        end
    end

    // error responder for unmapped addresses
    always_comb begin
        err_rsp         = '0;
        err_rsp.awready = e_wack;
        err_rsp.wready  = e_wack;
        err_rsp.bvalid  = e_bvalid;
        err_rsp.bresp   = RESP_DECERR;
        err_rsp.arready = e_rack;
        err_rsp.rvalid  = e_rvalid;
        err_rsp.rresp   = RESP_DECERR;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            e_wack   <= 1'b0;
            e_rack   <= 1'b0;
            e_bvalid <= 1'b0;
            e_rvalid <= 1'b0;
        end else begin
            e_wack <= 1'b0;
            e_rack <= 1'b0;
            if (!e_wack && !e_rack && !e_bvalid && !e_rvalid) begin
                if (err_req.arvalid)
                    e_rack <= 1'b1;
                else if (err_req.awvalid && err_req.wvalid)
                    e_wack <= 1'b1;
            end
            if (e_rack)
                e_rvalid <= 1'b1;
            if (e_wack)
                e_bvalid <= 1'b1;
            if (e_rvalid && m_in.rready)
                e_rvalid <= 1'b0;
            if (e_bvalid && m_in.bready)
                e_bvalid <= 1'b0;
        end
    end

endmodule

// ==== design/axil_master.sv ====
`timescale 1ns/1ps

module axil_master (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  soc_pkg::cmd_t      cmd,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output soc_pkg::rsp_t      rsp,
    output soc_pkg::axil_m2s_t bus_out,
    input  soc_pkg::axil_s2m_t bus_in
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_RESPOND
    } state_t;

    state_t state;
    logic   aw_pend;
    logic   w_pend;
    logic   ar_pend;
    addr_t  addr_q;
    data_t  data_q;
    strb_t  strb_q;
    rsp_t   rsp_q;

    // idle also means no result is waiting
    assign cmd_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);
    assign rsp       = rsp_q;

    always_comb begin
        bus_out         = '0;
        bus_out.awvalid = aw_pend;
        bus_out.awaddr  = addr_q;
        bus_out.wvalid  = w_pend;
        bus_out.wdata   = data_q;
        bus_out.wstrb   = strb_q;
        bus_out.bready  = (state == ST_WRITE);
        bus_out.arvalid = ar_pend;
        bus_out.araddr  = addr_q;
        bus_out.rready  = (state == ST_READ);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        aw_pend <= cmd.write;
                        w_pend  <= cmd.write;
                        ar_pend <= !cmd.write;
                        state   <= cmd.write ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    // address and data may be taken in either order
                    if (aw_pend && bus_in.awready)
                        aw_pend <= 1'b0;
                    if (w_pend && bus_in.wready)
                        w_pend <= 1'b0;
                    if (bus_in.bvalid)
                        state <= ST_RESPOND;
                end
                ST_READ: begin
                    if (ar_pend && bus_in.arready)
                        ar_pend <= 1'b0;
                    if (bus_in.rvalid)
                        state <= ST_RESPOND;
                end
                ST_RESPOND: begin
                    if (rsp_ready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command and result payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid) begin
            addr_q      <= cmd.addr;
            data_q      <= cmd.data;
            strb_q      <= cmd.strb;
            rsp_q.write <= cmd.write;
        end
        if (state == ST_WRITE && bus_in.bvalid) begin
            rsp_q.data <= '0;
            rsp_q.resp <= bus_in.bresp;
        end
        if (state == ST_READ && bus_in.rvalid) begin
            rsp_q.data <= bus_in.rdata;
            rsp_q.resp <= bus_in.rresp;
        end
    end

endmodule

// ==== design/clint_subsys.sv ====
`timescale 1ns/1ps

module clint_subsys #(
    parameter soc_pkg::addr_t CLINT_BASE = 32'h0200_0000,
    parameter soc_pkg::addr_t RAM_BASE   = 32'h8000_0000,
    parameter int             RAM_WORDS  = 64,
    parameter int             FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  soc_pkg::cmd_t cmd,
    output logic          rsp_valid,
    input  logic          rsp_ready,
    output soc_pkg::rsp_t rsp
);
    import soc_pkg::*;

    logic      q_valid;
    logic      q_ready;
    cmd_t      q_cmd;
    axil_m2s_t m_bus;
    axil_s2m_t m_resp;
    axil_m2s_t clint_req;
    axil_s2m_t clint_rsp;
    axil_m2s_t ram_req;
    axil_s2m_t ram_rsp;

    cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo0 (
        .clk      (clk),
        .reset    (reset),
        .in_valid (cmd_valid),
        .in_ready (cmd_ready),
        .in_cmd   (cmd),
        .out_valid(q_valid),
        .out_ready(q_ready),
        .out_cmd  (q_cmd)
    );

    axil_master master0 (
        .clk      (clk),
        .reset    (reset),
        .cmd_valid(q_valid),
        .cmd_ready(q_ready),
        .cmd      (q_cmd),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp      (rsp),
        .bus_out  (m_bus),
        .bus_in   (m_resp)
    );

    axil_decoder #(
        .CLINT_BASE(CLINT_BASE),
        .RAM_BASE  (RAM_BASE),
        .RAM_WORDS (RAM_WORDS)
    ) decoder0 (
        .clk      (clk),
        .reset    (reset),
        .m_in     (m_bus),
        .m_out    (m_resp),
        .clint_req(clint_req),
        .clint_rsp(clint_rsp),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    clint_timer #(
        .CLINT_BASE(CLINT_BASE)
    ) clint0 (
        .clk  (clk),
        .reset(reset),
        .req  (clint_req),
        .rsp  (clint_rsp)
    );

    scratch_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram0 (
        .clk  (clk),
        .reset(reset),
        .req  (ram_req),
        .rsp  (ram_rsp)
    );

endmodule

// ==== design/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer #(
    parameter soc_pkg::addr_t CLINT_BASE = 32'h0200_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  soc_pkg::axil_m2s_t req,
    output soc_pkg::axil_s2m_t rsp
);
    import soc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_ADDR,
        ST_READ_DATA,
        ST_WRITE_ADDR,
        ST_WRITE_RESP
    } state_t;

    state_t     state;
    mtime_t     mtime;
    logic [3:0] rd_off;
    logic       arready_q;
    logic       wack_q;
    logic       rvalid_q;
    logic       bvalid_q;
    data_t      rdata_q;
    resp_t      rresp_q;

    assign rd_off = 4'(req.araddr - CLINT_BASE);

    always_comb begin
        rsp         = '0;
        rsp.awready = wack_q;
        rsp.wready  = wack_q;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = RESP_OKAY;
        rsp.arready = arready_q;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
    end

    always_ff @(posedge clk) begin
        if (reset)
            mtime <= '0;
        else
            mtime <= mtime + 1'b1;
    end

    // reads win over a waiting write
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            arready_q <= 1'b0;
            wack_q    <= 1'b0;
            rvalid_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req.arvalid) begin
                        arready_q <= 1'b1;
                        state     <= ST_READ_ADDR;
                    end else if (req.awvalid && req.wvalid) begin
                        wack_q <= 1'b1;
                        state  <= ST_WRITE_ADDR;
                    end
                end
                ST_READ_ADDR: begin
                    arready_q <= 1'b0;
                    if (req.arvalid) begin
                        rvalid_q <= 1'b1;
                        state    <= ST_READ_DATA;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ_DATA: begin
                    if (req.rready) begin
                        rvalid_q <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_WRITE_ADDR: begin
                    // timer is read-only, the write is simply acknowledged
                    wack_q <= 1'b0;
                    if (req.awvalid && req.wvalid) begin
                        bvalid_q <= 1'b1;
                        state    <= ST_WRITE_RESP;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE_RESP: begin
                    if (req.bready) begin
                        bvalid_q <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_READ_ADDR && req.arvalid) begin
            case (rd_off)
                4'h0: begin
                    rdata_q <= mtime[31:0];
                    rresp_q <= RESP_OKAY;
                end
                4'h4: begin
                    rdata_q <= mtime[63:32];
                    rresp_q <= RESP_OKAY;
                end
                default: begin
                    rdata_q <= '0;
                    rresp_q <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== design/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    output logic          in_ready,
    input  soc_pkg::cmd_t in_cmd,
    output logic          out_valid,
    input  logic          out_ready,
    output soc_pkg::cmd_t out_cmd
);
    import soc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_t             slots [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             running;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // full fifo still takes a push when the head leaves this cycle
    assign out_valid = (count != '0);
    assign in_ready  = running && ((count != CNT_W'(FIFO_DEPTH)) || out_ready);
    assign out_cmd   = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            slots[wr_ptr] <= in_cmd;
    end

endmodule

// ==== design/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic               clk,
    input  logic               reset,
    input  soc_pkg::axil_m2s_t req,
    output soc_pkg::axil_s2m_t rsp
);
    import soc_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RACK,
        ST_RRESP,
        ST_WACK,
        ST_BRESP
    } state_t;

    state_t           state;
    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    data_t            rdata_q;

    // word index sits just above the byte offset
    assign rd_idx = req.araddr[IDX_W+1:2];
    assign wr_idx = req.awaddr[IDX_W+1:2];

    always_comb begin
        rsp         = '0;
        rsp.awready = (state == ST_WACK);
        rsp.wready  = (state == ST_WACK);
        rsp.bvalid  = (state == ST_BRESP);
        rsp.bresp   = RESP_OKAY;
        rsp.arready = (state == ST_RACK);
        rsp.rvalid  = (state == ST_RRESP);
        rsp.rdata   = rdata_q;
        rsp.rresp   = RESP_OKAY;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            for (int i = 0; i < RAM_WORDS; i++)
                mem[i] <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req.arvalid)
                        state <= ST_RACK;
                    else if (req.awvalid && req.wvalid)
                        state <= ST_WACK;
                end
                ST_RACK: begin
                    rdata_q <= mem[rd_idx];
                    state   <= ST_RRESP;
                end
                ST_RRESP: begin
                    if (req.rready)
                        state <= ST_IDLE;
                end
                ST_WACK: begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.wstrb[b])
                            mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                    state <= ST_BRESP;
                end
                ST_BRESP: begin
                    if (req.bready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/soc_pkg.sv ====
package soc_pkg;

    // widths with a meaning on the bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [63:0] mtime_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;
    localparam resp_t RESP_DECERR = 2'd3;

    // master-driven AXI4-Lite signals
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axil_m2s_t;

    // slave-driven AXI4-Lite signals
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axil_s2m_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t data;
        strb_t strb;
    } cmd_t;

    typedef struct packed {
        logic  write;
        data_t data;
        resp_t resp;
    } rsp_t;

endpackage

// ==== sources.f ====
design/soc_pkg.sv
design/cmd_fifo.sv
design/axil_master.sv
design/axil_decoder.sv
design/clint_timer.sv
design/scratch_ram.sv
design/clint_subsys.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic           clk,
    input  logic           reset,
    input  logic           rsp_valid,
    input  logic           rsp_ready,
    input  soc_pkg::rsp_t  rsp,
    input  logic           exp_valid,
    input  logic           exp_write,
    input  soc_pkg::resp_t exp_resp,
    input  soc_pkg::data_t exp_data,
    input  logic [1:0]     exp_kind,
    output int             checked_count,
    output int             error_count
);
    import soc_pkg::*;

    localparam logic [1:0] KIND_EXACT = 2'd0;
    localparam logic [1:0] KIND_MTIME = 2'd1;

    typedef struct packed {
        logic       write;
        resp_t      resp;
        data_t      data;
        logic [1:0] kind;
    } expect_t;

    expect_t pending [$];
    expect_t incoming;
    data_t   cycles;
    data_t   last_mtime;
    logic    seen_mtime;
    logic    holding;
    rsp_t    held_rsp;

    function automatic string resp_name(input resp_t r);
        case (r)
            RESP_OKAY:   return "OKAY";
            RESP_SLVERR: return "SLVERR";
            RESP_DECERR: return "DECERR";
            default:     return "EXOKAY";
        endcase
    endfunction

    task automatic compare_result();
        expect_t e;
        int      fails;
        e = pending.pop_front();
        fails = 0;
        if (rsp.write !== e.write) begin
            $display("Fail at %0t: rsp.write expected %b, got %b",
                     $time, e.write, rsp.write);
            fails++;
        end
        if (rsp.resp !== e.resp) begin
            $display("Fail at %0t: rsp.resp expected %s, got %s",
                     $time, resp_name(e.resp), resp_name(rsp.resp));
            fails++;
        end
        case (e.kind)
            KIND_EXACT: begin
                if (rsp.data !== e.data) begin
                    $display("Fail at %0t: rsp.data expected %h, got %h",
                             $time, e.data, rsp.data);
                    fails++;
                end
            end
            KIND_MTIME: begin
                // mtime only moves forward, and never runs ahead of the clock
                if (seen_mtime && rsp.data <= last_mtime) begin
                    $display("Fail at %0t: rsp.data expected above %h, got %h",
                             $time, last_mtime, rsp.data);
                    fails++;
                end
                if (rsp.data >= cycles) begin
                    $display("Fail at %0t: rsp.data expected below %h, got %h",
                             $time, cycles, rsp.data);
                    fails++;
                end
                last_mtime = rsp.data;
                seen_mtime = 1'b1;
            end
            default: begin
            end
        endcase
        checked_count++;
        error_count += fails;
        $display("test %0d %s %s: %s", checked_count, rsp.write ? "write" : "read",
                 resp_name(rsp.resp), (fails == 0) ? "ok" : "FAILED");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycles        = '0;
            last_mtime    = '0;
            seen_mtime    = 1'b0;
            holding       = 1'b0;
            held_rsp      = '0;
            checked_count = 0;
            error_count   = 0;
            pending.delete();
        end else begin
            // a stalled result must stay put until it is taken
            if (holding) begin
                if (rsp_valid !== 1'b1) begin
                    $display("rsp_valid dropped at %0t before the result was taken",
                             $time);
                    error_count++;
                end else if (rsp !== held_rsp) begin
                    $display("Fail at %0t: rsp expected %h, got %h",
                             $time, held_rsp, rsp);
                    error_count++;
                end
            end
            // older result first, then the command taken on this edge
            if (rsp_valid && rsp_ready) begin
                if (pending.size() == 0) begin
                    $display("a response arrived at %0t with no command waiting for it",
                             $time);
                    error_count++;
                end else begin
                    compare_result();
                end
            end
            if (exp_valid) begin
                incoming.write = exp_write;
                incoming.resp  = exp_resp;
                incoming.data  = exp_data;
                incoming.kind  = exp_kind;
                pending.push_back(incoming);
            end
            holding  = rsp_valid && !rsp_ready;
            held_rsp = rsp;
            cycles = cycles + 1'b1;
        end
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import soc_pkg::*;

    localparam addr_t       CLINT_BASE = 32'h0200_0000;
    localparam addr_t       RAM_BASE   = 32'h8000_0000;
    localparam int          RAM_WORDS  = 64;
    localparam int          FIFO_DEPTH = 4;
    localparam logic [31:0] SEED       = 32'h3362261d;

    localparam logic [1:0] KIND_EXACT  = 2'd0;
    localparam logic [1:0] KIND_MTIME  = 2'd1;
    localparam logic [1:0] KIND_NODATA = 2'd2;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        data_t      data;
        strb_t      strb;
        resp_t      exp_resp;
        data_t      exp_data;
        logic [1:0] kind;
    } row_t;

    logic       clk;
    logic       reset;
    logic       cmd_valid;
    logic       cmd_ready;
    cmd_t       cmd;
    logic       rsp_valid;
    logic       rsp_ready;
    rsp_t       rsp;
    logic       exp_valid;
    logic       exp_write;
    resp_t      exp_resp;
    data_t      exp_data;
    logic [1:0] exp_kind;
    logic       stall_on;
    int         checked_count;
    int         error_count;
    int         cycle_count;
    int         timeout_limit;
    int         bp_start;
    row_t       rows [$];
    data_t      ram_model [addr_t];

    clint_subsys #(
        .CLINT_BASE(CLINT_BASE),
        .RAM_BASE  (RAM_BASE),
        .RAM_WORDS (RAM_WORDS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd      (cmd),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp      (rsp)
    );

    tb_checker check0 (
        .clk          (clk),
        .reset        (reset),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp          (rsp),
        .exp_valid    (exp_valid),
        .exp_write    (exp_write),
        .exp_resp     (exp_resp),
        .exp_data     (exp_data),
        .exp_kind     (exp_kind),
        .checked_count(checked_count),
        .error_count  (error_count)
    );

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    task automatic push_row(input logic write, input addr_t addr, input data_t data,
                            input strb_t strb, input resp_t resp, input data_t edata,
                            input logic [1:0] kind);
        row_t r;
        r.write    = write;
        r.addr     = addr;
        r.data     = data;
        r.strb     = strb;
        r.exp_resp = resp;
        r.exp_data = edata;
        r.kind     = kind;
        rows.push_back(r);
    endtask

    // ram model starts at zero, like the ram after reset
    task automatic store_word(input addr_t offset, input data_t data, input strb_t strb);
        addr_t a;
        data_t old_word;
        a = RAM_BASE + offset;
        old_word = ram_model.exists(a) ? ram_model[a] : '0;
        ram_model[a] = merge_bytes(old_word, data, strb);
        push_row(1'b1, a, data, strb, RESP_OKAY, '0, KIND_EXACT);
    endtask

    task automatic load_word(input addr_t offset);
        addr_t a;
        data_t word;
        a = RAM_BASE + offset;
        word = ram_model.exists(a) ? ram_model[a] : '0;
        push_row(1'b0, a, '0, '0, RESP_OKAY, word, KIND_EXACT);
    endtask

    task automatic sample_mtime();
        push_row(1'b0, CLINT_BASE, '0, '0, RESP_OKAY, '0, KIND_MTIME);
    endtask

    task automatic expect_read(input addr_t addr, input resp_t resp, input data_t data);
        push_row(1'b0, addr, '0, '0, resp, data, KIND_EXACT);
    endtask

    task automatic expect_write(input addr_t addr, input data_t data, input resp_t resp);
        push_row(1'b1, addr, data, 4'hf, resp, '0, KIND_EXACT);
    endtask

    task automatic build_table();
        // write, read-back and byte lanes
        store_word(32'h000, $urandom(), 4'hf);
        store_word(32'h004, $urandom(), 4'hf);
        load_word(32'h000);
        load_word(32'h004);
        store_word(32'h000, $urandom(), 4'b0101);
        load_word(32'h000);
        store_word(32'h004, $urandom(), 4'b1000);
        load_word(32'h004);
        store_word(32'h0fc, $urandom(), 4'hf);
        load_word(32'h0fc);
        // timer
        sample_mtime();
        sample_mtime();
        sample_mtime();
        expect_read(CLINT_BASE + 32'h4, RESP_OKAY, '0);
        push_row(1'b1, CLINT_BASE, $urandom(), 4'hf, RESP_OKAY, '0, KIND_NODATA);
        sample_mtime();
        expect_read(CLINT_BASE + 32'h8, RESP_SLVERR, '0);
        expect_read(CLINT_BASE + 32'hc, RESP_SLVERR, '0);
        // outside both windows
        expect_read(32'h1000_0000, RESP_DECERR, '0);
        expect_write(32'h1000_0000, $urandom(), RESP_DECERR);
        expect_read(RAM_BASE + addr_t'(RAM_WORDS * 4), RESP_DECERR, '0);
        expect_read(CLINT_BASE + 32'h10, RESP_DECERR, '0);
        // from here on rsp_ready stalls at random
        bp_start = rows.size();
        store_word(32'h010, $urandom(), 4'hf);
        store_word(32'h014, $urandom(), 4'hf);
        load_word(32'h010);
        sample_mtime();
        expect_write(32'h2000_0000, $urandom(), RESP_DECERR);
        load_word(32'h014);
        expect_read(CLINT_BASE + 32'h8, RESP_SLVERR, '0);
        sample_mtime();
        store_word(32'h010, $urandom(), 4'b0011);
        load_word(32'h010);
        store_word(32'h014, $urandom(), 4'b0110);
        load_word(32'h014);
    endtask

    task automatic apply_row(input row_t r);
        cmd_valid = 1'b1;
        cmd.write = r.write;
        cmd.addr  = r.addr;
        cmd.data  = r.data;
        cmd.strb  = r.strb;
        exp_valid = 1'b1;
        exp_write = r.write;
        exp_resp  = r.exp_resp;
        exp_data  = r.exp_data;
        exp_kind  = r.kind;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (stall_on)
                rsp_ready = ($urandom_range(2, 0) == 0);
            else
                rsp_ready = 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        @(posedge clk);
        timeout_limit = rows.size() * 40 + 200;
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: results still missing after %0d cycles", timeout_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        build_table();
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        exp_valid = 1'b0;
        exp_write = 1'b0;
        exp_resp  = '0;
        exp_data  = '0;
        exp_kind  = '0;
        stall_on  = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // cmd_ready only changes on a rising edge, so a row set here always transfers
        for (int i = 0; i < rows.size(); i++) begin
            if (i == bp_start)
                stall_on = 1'b1;
            @(negedge clk);
            while (!cmd_ready) begin
                cmd_valid = 1'b0;
                exp_valid = 1'b0;
                @(negedge clk);
            end
            apply_row(rows[i]);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        exp_valid = 1'b0;

        while (checked_count < rows.size())
            @(negedge clk);
        // late duplicates would still show up here
        repeat (10) @(negedge clk);
        $display("%0d of %0d tests checked, %0d errors", checked_count, rows.size(),
                 error_count);
        if (error_count == 0 && checked_count == rows.size())
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
